//--- Makefile
VERILATOR ?= verilator
TOP       := mandelbrot_tb
FILE_LIST := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
RUN_FLAGS := +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -qx "ALL TESTS PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
+incdir+verif
logic/fixed_point_pkg.sv
logic/pixel_pkg.sv
logic/escape_iterator.sv
logic/color_map.sv
logic/frame_walker.sv
logic/mandelbrot_renderer.sv
verif/mandelbrot_assertions.sv
verif/mandelbrot_tb.sv

//--- logic/color_map.sv
`timescale 1ns/1ns
`default_nettype none

module color_map (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         result_valid,
	input  fixed_point_pkg::iter_count_t result_count,
	input  pixel_pkg::pixel_addr_t       pixel_addr,
	output pixel_pkg::pixel_write_t      pixel_write
);

	pixel_pkg::color_t color;

	// Registered write fields
	logic write_we;
	pixel_pkg::pixel_addr_t write_addr;
	pixel_pkg::color_t write_color;

	// Band lookup, slowest escape first
	always_comb begin
		if (result_count >= fixed_point_pkg::ITER_MAX) begin
			color = pixel_pkg::COLOR_SET;
		end else if (result_count >= pixel_pkg::ITER_DIV2) begin
			color = pixel_pkg::COLOR_DIV2;
		end else if (result_count >= pixel_pkg::ITER_DIV4) begin
			color = pixel_pkg::COLOR_DIV4;
		end else if (result_count >= pixel_pkg::ITER_DIV8) begin
			color = pixel_pkg::COLOR_DIV8;
		end else if (result_count >= pixel_pkg::ITER_DIV16) begin
			color = pixel_pkg::COLOR_DIV16;
		end else if (result_count >= pixel_pkg::ITER_DIV32) begin
			color = pixel_pkg::COLOR_DIV32;
		end else if (result_count >= pixel_pkg::ITER_DIV64) begin
			color = pixel_pkg::COLOR_DIV64;
		end else begin
			// Escaped almost at once
			color = pixel_pkg::COLOR_FAST;
		end
	end

	// Strobe follows the result by one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			write_we <= 1'b0;
		end else begin
			write_we <= result_valid;
		end
	end

	// Address and color captured in the same cycle as the strobe
	always_ff @(posedge clk) begin
		if (result_valid) begin
			write_addr <= pixel_addr;
			write_color <= color;
		end
	end

	assign pixel_write = '{we: write_we, addr: write_addr, color: write_color};

endmodule

`default_nettype wire

//--- logic/escape_iterator.sv
`timescale 1ns/1ns
`default_nettype none

module escape_iterator (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         point_load,
	input  fixed_point_pkg::fixed_t      point_re,
	input  fixed_point_pkg::fixed_t      point_im,
	output logic                         result_valid,
	output fixed_point_pkg::iter_count_t result_count
);

	// 4.23 multiply, keeps the sign and product bits 48..23
	function automatic fixed_point_pkg::fixed_t fx_mul(
		input fixed_point_pkg::fixed_t a,
		input fixed_point_pkg::fixed_t b
	);
		logic signed [53:0] full;
		full = a * b;
		return {full[53], full[fixed_point_pkg::FRAC_BITS +: 26]};
	endfunction

	fixed_point_pkg::iter_state_t state;

	// Point under test
	fixed_point_pkg::fixed_t c_re;
	fixed_point_pkg::fixed_t c_im;

	// Running z and step count
	fixed_point_pkg::fixed_t zr;
	fixed_point_pkg::fixed_t zi;
	fixed_point_pkg::iter_count_t count;

	// One step of z -> z^2 + c
	fixed_point_pkg::fixed_t zr_sq;
	fixed_point_pkg::fixed_t zi_sq;
	fixed_point_pkg::fixed_t zr_zi;
	fixed_point_pkg::fixed_t mag_sq;
	fixed_point_pkg::fixed_t zr_next;
	fixed_point_pkg::fixed_t zi_next;
	fixed_point_pkg::iter_count_t count_next;
	logic escape;

	////////////////////
	// Step datapath
	////////////////////

	assign zr_sq = fx_mul(zr, zr);
	assign zi_sq = fx_mul(zi, zi);
	assign zr_zi = fx_mul(zr, zi);

	// Sums wrap in 27 bits
	assign zr_next = zr_sq - zi_sq + c_re;
	assign zi_next = zr_zi + zr_zi + c_im;
	assign mag_sq = zr_sq + zi_sq;
	assign count_next = count + 1'b1;

	// Magnitude, either new component out of range, or budget used up
	assign escape = (mag_sq > fixed_point_pkg::ESCAPE_MAG_SQ)
		|| (zr_next > fixed_point_pkg::ESCAPE_COMPONENT)
		|| (zr_next < -fixed_point_pkg::ESCAPE_COMPONENT)
		|| (zi_next > fixed_point_pkg::ESCAPE_COMPONENT)
		|| (zi_next < -fixed_point_pkg::ESCAPE_COMPONENT)
		|| (count_next == fixed_point_pkg::ITER_MAX);

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fixed_point_pkg::IDLE;
		end else begin
			case (state)
				fixed_point_pkg::IDLE: begin
					if (point_load) begin
						state <= fixed_point_pkg::CALC;
					end
				end
				fixed_point_pkg::CALC: begin
					// Last step still counts
					if (escape) begin
						state <= fixed_point_pkg::DONE;
					end
				end
				// Single result cycle, then ready again
				fixed_point_pkg::DONE: state <= fixed_point_pkg::IDLE;
				default: state <= fixed_point_pkg::IDLE;
			endcase
		end
	end

	// z, c and count
	always_ff @(posedge clk) begin
		if (state == fixed_point_pkg::IDLE && point_load) begin
			c_re <= point_re;
			c_im <= point_im;
			zr <= '0;
			zi <= '0;
			count <= '0;
		end else if (state == fixed_point_pkg::CALC) begin
			zr <= zr_next;
			zi <= zi_next;
			count <= count_next;
		end
	end

	// Count is stable for the whole DONE cycle
	assign result_valid = (state == fixed_point_pkg::DONE);
	assign result_count = count;

endmodule

`default_nettype wire

//--- logic/fixed_point_pkg.sv
`default_nettype none

package fixed_point_pkg;

	////////////////////
	// Number format
	////////////////////

	// Fraction width of the 4.23 format
	localparam int FRAC_BITS = 23;

	// Signed 4.23, 27 bits total
	typedef logic signed [26:0] fixed_t;

	////////////////////
	// Iteration limits
	////////////////////

	// Enough bits to hold ITER_MAX
	typedef logic [10:0] iter_count_t;

	// Hard stop for points inside the set
	localparam iter_count_t ITER_MAX = 11'd1000;

	// Bound on zr^2 + zi^2, i.e. 4.0
	localparam fixed_t ESCAPE_MAG_SQ = fixed_t'(4 << FRAC_BITS);

	// Bound on each new component, i.e. 2.0
	localparam fixed_t ESCAPE_COMPONENT = fixed_t'(2 << FRAC_BITS);

	// Iterator FSM
	typedef enum logic [1:0] {
		IDLE,
		CALC,
		DONE
	} iter_state_t;

endpackage

`default_nettype wire

//--- logic/frame_walker.sv
`timescale 1ns/1ns
`default_nettype none

module frame_walker #(
	parameter int FRAME_W = 640,
	parameter int FRAME_H = 480
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    start,
	input  pixel_pkg::view_t        view,
	input  logic                    result_valid,
	output logic                    point_load,
	output fixed_point_pkg::fixed_t point_re,
	output fixed_point_pkg::fixed_t point_im,
	output pixel_pkg::pixel_addr_t  pixel_addr,
	output logic                    busy,
	output logic                    done
);

	// Raster counters sized to the frame
	typedef logic [$clog2(FRAME_W)-1:0] x_count_t;
	typedef logic [$clog2(FRAME_H)-1:0] y_count_t;

	pixel_pkg::walk_state_t state;

	x_count_t pixel_x;
	y_count_t pixel_y;

	// Captured view, only what is needed after the start
	fixed_point_pkg::fixed_t x_start_q;
	fixed_point_pkg::fixed_t step_q;

	// Coordinate of the current pixel
	fixed_point_pkg::fixed_t cur_re;
	fixed_point_pkg::fixed_t cur_im;

	logic row_end;
	logic frame_end;

	assign row_end = (pixel_x == x_count_t'(FRAME_W - 1));
	assign frame_end = row_end && (pixel_y == y_count_t'(FRAME_H - 1));

	////////////////////
	// Walk FSM
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= pixel_pkg::IDLE;
			done <= 1'b0;
		end else begin
			// Pulse lands one cycle after the last write
			done <= (state == pixel_pkg::FINISH);
			case (state)
				pixel_pkg::IDLE: begin
					if (start) begin
						state <= pixel_pkg::ISSUE;
					end
				end
				pixel_pkg::ISSUE: state <= pixel_pkg::WAIT_RESULT;
				pixel_pkg::WAIT_RESULT: begin
					if (result_valid) begin
						state <= frame_end ? pixel_pkg::FINISH : pixel_pkg::ISSUE;
					end
				end
				// Last write is on the bus during this state
				pixel_pkg::FINISH: state <= pixel_pkg::IDLE;
				default: state <= pixel_pkg::IDLE;
			endcase
		end
	end

	////////////////////
	// Raster stepping
	////////////////////

	always_ff @(posedge clk) begin
		if (state == pixel_pkg::IDLE && start) begin
			x_start_q <= view.x_start;
			step_q <= view.step;
			cur_re <= view.x_start;
			cur_im <= view.y_start;
			pixel_x <= '0;
			pixel_y <= '0;
			pixel_addr <= '0;
		end else if (state == pixel_pkg::WAIT_RESULT && result_valid && !frame_end) begin
			// Address changes only after the color map has sampled it
			pixel_addr <= pixel_addr + 1'b1;
			if (row_end) begin
				// Next row, imaginary axis goes down
				pixel_x <= '0;
				pixel_y <= pixel_y + 1'b1;
				cur_re <= x_start_q;
				cur_im <= cur_im - step_q;
			end else begin
				pixel_x <= pixel_x + 1'b1;
				cur_re <= cur_re + step_q;
			end
		end
	end

	assign point_load = (state == pixel_pkg::ISSUE);
	assign point_re = cur_re;
	assign point_im = cur_im;
	assign busy = (state != pixel_pkg::IDLE);

endmodule

`default_nettype wire

//--- logic/mandelbrot_renderer.sv
`timescale 1ns/1ns
`default_nettype none

module mandelbrot_renderer #(
	parameter int FRAME_W = 640,
	parameter int FRAME_H = 480
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    start,
	input  pixel_pkg::view_t        view,
	output logic                    busy,
	output logic                    done,
	output pixel_pkg::pixel_write_t pixel_write
);

	// Walker to iterator
	logic point_load;
	fixed_point_pkg::fixed_t point_re;
	fixed_point_pkg::fixed_t point_im;

	// Iterator result, shared by walker and color map
	logic result_valid;
	fixed_point_pkg::iter_count_t result_count;

	// Address of the pixel in flight
	pixel_pkg::pixel_addr_t pixel_addr;

	frame_walker #(
		.FRAME_W(FRAME_W),
		.FRAME_H(FRAME_H)
	) walker_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.view(view),
		.result_valid(result_valid),
		.point_load(point_load),
		.point_re(point_re),
		.point_im(point_im),
		.pixel_addr(pixel_addr),
		.busy(busy),
		.done(done)
	);

	escape_iterator iterator_i (
		.clk(clk),
		.reset(reset),
		.point_load(point_load),
		.point_re(point_re),
		.point_im(point_im),
		.result_valid(result_valid),
		.result_count(result_count)
	);

	color_map color_map_i (
		.clk(clk),
		.reset(reset),
		.result_valid(result_valid),
		.result_count(result_count),
		.pixel_addr(pixel_addr),
		.pixel_write(pixel_write)
	);

endmodule

`default_nettype wire

//--- logic/pixel_pkg.sv
`default_nettype none

package pixel_pkg;

	// RGB 3-3-2, red in the top bits
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} color_t;

	// Row-major framebuffer address, 640x480 fits
	typedef logic [18:0] pixel_addr_t;

	// Upper left corner and pixel pitch of the rendered window
	typedef struct packed {
		fixed_point_pkg::fixed_t x_start;
		fixed_point_pkg::fixed_t y_start;
		fixed_point_pkg::fixed_t step;
	} view_t;

	// One framebuffer write
	typedef struct packed {
		logic        we;
		pixel_addr_t addr;
		color_t      color;
	} pixel_write_t;

	// Walker FSM
	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT_RESULT,
		FINISH
	} walk_state_t;

	////////////////////
	// Color bands
	////////////////////

	// Count thresholds, halving from the iteration limit
	localparam fixed_point_pkg::iter_count_t ITER_DIV2 = fixed_point_pkg::ITER_MAX >> 1;
	localparam fixed_point_pkg::iter_count_t ITER_DIV4 = fixed_point_pkg::ITER_MAX >> 2;
	localparam fixed_point_pkg::iter_count_t ITER_DIV8 = fixed_point_pkg::ITER_MAX >> 3;
	localparam fixed_point_pkg::iter_count_t ITER_DIV16 = fixed_point_pkg::ITER_MAX >> 4;
	localparam fixed_point_pkg::iter_count_t ITER_DIV32 = fixed_point_pkg::ITER_MAX >> 5;
	localparam fixed_point_pkg::iter_count_t ITER_DIV64 = fixed_point_pkg::ITER_MAX >> 6;

	// Band colors
	localparam color_t COLOR_SET = 8'b000_000_00;
	localparam color_t COLOR_DIV2 = 8'b011_001_00;
	localparam color_t COLOR_DIV4 = 8'b011_001_00;
	localparam color_t COLOR_DIV8 = 8'b101_010_01;
	localparam color_t COLOR_DIV16 = 8'b011_001_01;
	localparam color_t COLOR_DIV32 = 8'b001_001_01;
	localparam color_t COLOR_DIV64 = 8'b011_010_10;
	localparam color_t COLOR_FAST = 8'b100_100_10;

endpackage

`default_nettype wire

//--- verif/mandelbrot_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module mandelbrot_assertions (
	input logic                    clk,
	input logic                    reset,
	input logic                    busy,
	input logic                    done,
	input logic                    point_load,
	input logic                    result_valid,
	input pixel_pkg::pixel_write_t pixel_write
);

	// Failure tally, read by the testbench at the end
	int failures;

	initial failures = 0;

	// Writes only inside a frame
	write_inside_frame: assert property (@(posedge clk) disable iff (reset)
		pixel_write.we |-> busy)
		else begin
			$error("framebuffer write while the renderer is idle");
			failures++;
		end

	// done is a single-cycle pulse
	done_single_pulse: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
		else begin
			$error("done held high for two cycles");
			failures++;
		end

	// At least one CALC cycle between load and result
	no_early_result: assert property (@(posedge clk) disable iff (reset)
		point_load |=> !result_valid)
		else begin
			$error("result_valid on the cycle right after point_load");
			failures++;
		end

endmodule

bind mandelbrot_renderer mandelbrot_assertions assertions_i (
	.clk(clk),
	.reset(reset),
	.busy(busy),
	.done(done),
	.point_load(point_load),
	.result_valid(result_valid),
	.pixel_write(pixel_write)
);

`default_nettype wire

//--- verif/mandelbrot_model.svh
`ifndef MANDELBROT_MODEL_SVH
`define MANDELBROT_MODEL_SVH

`default_nettype none

// 4.23 product with the sign bit and bits 48 down to 23
function automatic fixed_point_pkg::fixed_t fixed_product(
	input fixed_point_pkg::fixed_t a,
	input fixed_point_pkg::fixed_t b
);
	longint full;
	full = longint'(a) * longint'(b);
	return {full[53], full[48:23]};
endfunction

// Steps of z -> z^2 + c until escape or the 1000 step limit
function automatic int escape_count(
	input fixed_point_pkg::fixed_t c_re,
	input fixed_point_pkg::fixed_t c_im
);
	fixed_point_pkg::fixed_t zr;
	fixed_point_pkg::fixed_t zi;
	fixed_point_pkg::fixed_t zr_sq;
	fixed_point_pkg::fixed_t zi_sq;
	fixed_point_pkg::fixed_t zr_zi;
	fixed_point_pkg::fixed_t mag;
	fixed_point_pkg::fixed_t zr_new;
	fixed_point_pkg::fixed_t zi_new;
	zr = '0;
	zi = '0;
	for (int n = 1; n <= 1000; n++) begin
		zr_sq = fixed_product(zr, zr);
		zi_sq = fixed_product(zi, zi);
		zr_zi = fixed_product(zr, zi);
		// All sums wrap in 27 bits
		zr_new = zr_sq - zi_sq + c_re;
		zi_new = zr_zi + zr_zi + c_im;
		mag = zr_sq + zi_sq;
		// 4.0 is 2^25 and 2.0 is 2^24 in this format
		if (mag > 33554432 || zr_new > 16777216 || zr_new < -16777216
				|| zi_new > 16777216 || zi_new < -16777216 || n == 1000) begin
			return n;
		end
		zr = zr_new;
		zi = zi_new;
	end
	return 1000;
endfunction

// Band table with the slowest escape first
function automatic pixel_pkg::color_t band_color(input int n);
	if (n >= 1000) return pixel_pkg::color_t'(8'h00);
	if (n >= 500) return pixel_pkg::color_t'(8'h64);
	if (n >= 250) return pixel_pkg::color_t'(8'h64);
	if (n >= 125) return pixel_pkg::color_t'(8'hA9);
	if (n >= 62) return pixel_pkg::color_t'(8'h65);
	if (n >= 31) return pixel_pkg::color_t'(8'h25);
	if (n >= 15) return pixel_pkg::color_t'(8'h6A);
	return pixel_pkg::color_t'(8'h92);
endfunction

// Real part of column x
function automatic fixed_point_pkg::fixed_t column_re(input pixel_pkg::view_t v, input int x);
	return v.x_start + fixed_point_pkg::fixed_t'(x * v.step);
endfunction

// Imaginary part of row y going down the screen
function automatic fixed_point_pkg::fixed_t row_im(input pixel_pkg::view_t v, input int y);
	return v.y_start - fixed_point_pkg::fixed_t'(y * v.step);
endfunction

`default_nettype wire

`endif

//--- verif/mandelbrot_tb.sv
`timescale 1ns/1ns
`include "mandelbrot_model.svh"
`default_nettype none

module mandelbrot_tb;

	localparam int FRAME_W = 8;
	localparam int FRAME_H = 6;
	localparam int FRAME_PIXELS = FRAME_W * FRAME_H;
	localparam int NUM_FRAMES = 5;
	localparam int NUM_TESTS = NUM_FRAMES + 1;
	localparam int CLK_PERIOD = 40;
	// Worst case for one frame, every pixel at the limit
	localparam int FRAME_CYCLES = FRAME_PIXELS * (int'(fixed_point_pkg::ITER_MAX) + 4);
	localparam longint WATCHDOG_CYCLES = longint'(NUM_TESTS) * FRAME_CYCLES;

	typedef enum {OUTSIDE, INSIDE, MIXED} frame_kind_t;

	typedef struct {
		string            name;
		pixel_pkg::view_t view;
		frame_kind_t      kind;
	} test_entry_t;

	logic clk;
	logic reset;
	logic start;
	pixel_pkg::view_t view;
	logic busy;
	logic done;
	pixel_pkg::pixel_write_t pixel_write;

	test_entry_t tests [NUM_FRAMES];

	// Collected writes of the current frame
	pixel_pkg::pixel_addr_t got_addr [$];
	pixel_pkg::color_t got_color [$];
	int done_count;
	int writes_at_done;
	int busy_at_done;

	int errors;
	int passed;
	int failed;

	mandelbrot_renderer #(
		.FRAME_W(FRAME_W),
		.FRAME_H(FRAME_H)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.view(view),
		.busy(busy),
		.done(done),
		.pixel_write(pixel_write)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Sampled away from the driving edge
	always @(negedge clk) begin
		if (!reset) begin
			if (pixel_write.we) begin
				got_addr.push_back(pixel_write.addr);
				got_color.push_back(pixel_write.color);
			end
			if (done) begin
				done_count++;
				writes_at_done = got_addr.size();
				busy_at_done = int'(busy);
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	////////////////////
	// Checks
	////////////////////

	task automatic check_color(input string name, input pixel_pkg::color_t expected,
			input pixel_pkg::color_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input pixel_pkg::pixel_addr_t expected,
			input pixel_pkg::pixel_addr_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("PASS %s", name);
			passed++;
		end else begin
			$display("FAIL %s", name);
			failed++;
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////

	function automatic fixed_point_pkg::fixed_t to_fixed(input real value);
		return fixed_point_pkg::fixed_t'($rtoi(value * 8388608.0));
	endfunction

	task automatic add_test(input int idx, input string name, input real x_start,
			input real y_start, input fixed_point_pkg::fixed_t step, input frame_kind_t kind);
		tests[idx].name = name;
		tests[idx].view.x_start = to_fixed(x_start);
		tests[idx].view.y_start = to_fixed(y_start);
		tests[idx].view.step = step;
		tests[idx].kind = kind;
	endtask

	// Nothing may move without a start
	task automatic check_idle();
		int errors_before;
		errors_before = errors;
		repeat (20) begin
			@(negedge clk);
			check_count("idle_after_reset busy", 0, int'(busy));
			check_count("idle_after_reset done", 0, int'(done));
			check_count("idle_after_reset write strobe", 0, int'(pixel_write.we));
		end
		@(posedge clk);
		#2;
		report_test("idle_after_reset", errors_before);
	endtask

	task automatic run_frame(input test_entry_t entry);
		int errors_before;
		int cycles;
		string label;
		pixel_pkg::color_t expected;
		errors_before = errors;
		got_addr.delete();
		got_color.delete();
		done_count = 0;
		writes_at_done = 0;
		busy_at_done = 1;
		view = entry.view;
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		cycles = 0;
		while (got_addr.size() == 0 && cycles < FRAME_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		#2;
		// Second start mid-frame, with a different view, must be ignored
		check_count({entry.name, " busy during frame"}, 1, int'(busy));
		view = '0;
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		while (done_count == 0 && cycles < FRAME_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (done_count == 0) begin
			$display("ERROR %s: frame did not finish within %0d cycles", entry.name, cycles);
			errors++;
		end
		repeat (20) @(posedge clk);
		#2;
		check_count({entry.name, " busy after done"}, 0, int'(busy));
		check_count({entry.name, " busy with done"}, 0, busy_at_done);
		check_count({entry.name, " done pulses"}, 1, done_count);
		check_count({entry.name, " writes before done"}, FRAME_PIXELS, writes_at_done);
		check_count({entry.name, " write count"}, FRAME_PIXELS, got_addr.size());
		for (int i = 0; i < got_addr.size(); i++) begin
			label = $sformatf("%s pixel %0d", entry.name, i);
			check_addr(label, pixel_pkg::pixel_addr_t'(i), got_addr[i]);
			expected = band_color(escape_count(column_re(entry.view, i % FRAME_W),
				row_im(entry.view, i / FRAME_W)));
			check_color(label, expected, got_color[i]);
			// Known outcome of the whole frame
			if (entry.kind == INSIDE) begin
				check_color(label, pixel_pkg::color_t'(8'h00), got_color[i]);
			end else if (entry.kind == OUTSIDE) begin
				check_color(label, pixel_pkg::color_t'(8'h92), got_color[i]);
			end
		end
		report_test(entry.name, errors_before);
	endtask

	initial begin
		int assert_failures;
		void'($urandom(38149));
		reset = 1'b1;
		start = 1'b0;
		view = '0;
		errors = 0;
		passed = 0;
		failed = 0;
		done_count = 0;
		add_test(0, "outside_set", 3.0, 1.0, to_fixed(0.125), OUTSIDE);
		add_test(1, "inside_cardioid", -0.3, 0.1, to_fixed(0.0001), INSIDE);
		add_test(2, "boundary", -2.0, 1.2, to_fixed(0.4), MIXED);
		// Steps from 0.05 to 0.45 keep the window inside 4.23 range
		add_test(3, "random_step_a", -2.0, 1.2,
			fixed_point_pkg::fixed_t'($urandom_range(3774873, 419430)), MIXED);
		add_test(4, "random_step_b", -2.0, 1.2,
			fixed_point_pkg::fixed_t'($urandom_range(3774873, 419430)), MIXED);
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		check_idle();
		for (int t = 0; t < NUM_FRAMES; t++) begin
			run_frame(tests[t]);
		end
		assert_failures = dut_i.assertions_i.failures;
		$display("Tests: %0d passed, %0d failed, %0d assertion failures",
			passed, failed, assert_failures);
		if (failed == 0 && assert_failures == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
